// ==== include/fv_bank_cfg.svh ====
`ifndef FV_BANK_CFG_SVH
`define FV_BANK_CFG_SVH

// width of one feature word in bits.
`define FV_BW 32

// longest vector a PE may ask for, in words.
`define MAX_FV_NUM 8

// number of edge PEs that can be tagged on a request.
`define NUM_EDGE_PE 4

// bank SRAM size in words; FV_ADDR_W must cover it.
`define FV_BANK_DEPTH 256
`define FV_ADDR_W 8

`endif

// ==== hw/fv_bank_pkg.sv ====
`default_nettype none

`include "fv_bank_cfg.svh"

package fv_bank_pkg;

    // vector length, wide enough to hold MAX_FV_NUM itself.
    typedef logic [$clog2(`MAX_FV_NUM):0] fv_num_t;

    typedef logic [$clog2(`NUM_EDGE_PE)-1:0] fv_tag_t;

    // one word of a loader burst.
    typedef struct packed {
        logic                  sos;
        logic                  eos;
        logic [`FV_ADDR_W-1:0] addr;
        logic [`FV_BW-1:0]     data;
    } fv_load_t;

    typedef struct packed {
        logic                  valid;
        logic [`FV_ADDR_W-1:0] addr;
        fv_tag_t               pe_tag;
    } fv_read_req_t;

    // cen is the read enable, wen the write enable.
    typedef struct packed {
        logic                  cen;
        logic                  wen;
        logic [`FV_ADDR_W-1:0] addr;
        logic [`FV_BW-1:0]     wdata;
    } fv_sram_req_t;

    typedef struct packed {
        logic              valid;
        logic              sos;
        logic              eos;
        fv_tag_t           pe_tag;
        logic [`FV_BW-1:0] data;
    } fv_stream_t;

endpackage

`default_nettype wire

// ==== hw/fv_bank_cfg_regs.sv ====
`default_nettype none

`include "fv_bank_cfg.svh"

module fv_bank_cfg_regs (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 cfg_we,
    input  wire fv_bank_pkg::fv_num_t cfg_wdata,
    output fv_bank_pkg::fv_num_t      num_fv,
    output logic                      cfg_error
);

    import fv_bank_pkg::*;

    localparam fv_num_t max_num = fv_num_t'(`MAX_FV_NUM);

    logic legal;

    // a length of zero or beyond the largest vector is refused.
    assign legal = (cfg_wdata != '0) && (cfg_wdata <= max_num);

    always_ff @(posedge clk) begin
        if (reset) begin
            num_fv    <= fv_num_t'(1);
            cfg_error <= 1'b0;
        end else if (cfg_we) begin
            if (legal) begin
                num_fv <= cfg_wdata;
            end else begin
                // sticky until the next reset.
                cfg_error <= 1'b1;
            end
        end
    end

    // the controller relies on a length that is never zero.
    num_fv_range_a: assert property (
        @(posedge clk) disable iff (reset)
        (num_fv != '0) && (num_fv <= max_num)
    ) else $error("vector length %0d out of range", num_fv);

endmodule

`default_nettype wire

// ==== hw/fv_sram.sv ====
`default_nettype none

`include "fv_bank_cfg.svh"

module fv_sram (
    input  wire logic                      clk,
    input  wire fv_bank_pkg::fv_sram_req_t sram_req,
    output logic [`FV_BW-1:0]              rdata
);

    logic [`FV_BW-1:0] mem [`FV_BANK_DEPTH];

    // single port; read data shows up on the edge after cen.
    always_ff @(posedge clk) begin
        if (sram_req.wen) begin
            mem[sram_req.addr] <= sram_req.wdata;
        end
        if (sram_req.cen) begin
            rdata <= mem[sram_req.addr];
        end
    end

    // the controller must never read and write the one port together.
    port_conflict_a: assert property (
        @(posedge clk) sram_req.wen |-> !sram_req.cen
    ) else $error("read and write issued together at address %0d", sram_req.addr);

endmodule

`default_nettype wire

// ==== hw/fv_bank_ctrl.sv ====
`default_nettype none

`include "fv_bank_cfg.svh"

module fv_bank_ctrl (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire fv_bank_pkg::fv_num_t      num_fv,
    input  wire fv_bank_pkg::fv_load_t     load,
    input  wire fv_bank_pkg::fv_read_req_t req,
    input  wire logic [`FV_BW-1:0]         rdata,
    output fv_bank_pkg::fv_sram_req_t      sram_req,
    output fv_bank_pkg::fv_stream_t        stream,
    output logic                           busy
);

    import fv_bank_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_write_fv,
        st_stream
    } state_t;

    state_t                state;
    state_t                state_next;
    fv_sram_req_t          sram_req_next;
    logic [`FV_ADDR_W-1:0] rd_addr;
    fv_num_t               rd_cnt;
    fv_num_t               out_cnt;
    fv_num_t               num_q;
    fv_tag_t               tag_q;
    logic                  start_rd;
    logic                  issue_rd;
    logic                  rvalid;
    logic                  last_out;

    // a load sos in idle takes the bank and drops a request in the same cycle.
    assign start_rd = (state == st_idle) && !load.sos && req.valid;
    assign issue_rd = (state == st_stream) && (rd_cnt != num_q);

    // rvalid marks the cycle in which rdata holds a word of the vector.
    assign last_out = rvalid && (out_cnt == fv_num_t'(num_q - 1'b1));

    always_comb begin
        state_next          = state;
        sram_req_next       = '0;
        sram_req_next.wdata = load.data;
        case (state)
            st_idle: begin
                if (load.sos) begin
                    sram_req_next.wen  = 1'b1;
                    sram_req_next.addr = load.addr;
                    // a one-word burst is written without leaving idle.
                    if (!load.eos)
                        state_next = st_write_fv;
                end else if (req.valid) begin
                    sram_req_next.cen  = 1'b1;
                    sram_req_next.addr = req.addr;
                    state_next         = st_stream;
                end
            end
            st_write_fv: begin
                sram_req_next.wen  = 1'b1;
                sram_req_next.addr = load.addr;
                if (load.eos)
                    state_next = st_idle;
            end
            st_stream: begin
                if (issue_rd) begin
                    sram_req_next.cen  = 1'b1;
                    sram_req_next.addr = rd_addr;
                end
                // stay until the last word has been registered out.
                if (last_out)
                    state_next = st_idle;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= st_idle;
            sram_req.cen <= 1'b0;
            sram_req.wen <= 1'b0;
            rvalid       <= 1'b0;
        end else begin
            state    <= state_next;
            sram_req <= sram_req_next;
            rvalid   <= sram_req.cen;
        end
    end

    // rd_cnt counts reads issued, out_cnt trails it by the SRAM latency.
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_cnt  <= '0;
            out_cnt <= '0;
        end else if (start_rd) begin
            rd_cnt  <= fv_num_t'(1);
            out_cnt <= '0;
        end else if (state == st_stream) begin
            if (issue_rd)
                rd_cnt <= rd_cnt + 1'b1;
            if (rvalid)
                out_cnt <= out_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start_rd) begin
            rd_addr <= req.addr + 1'b1;
            tag_q   <= req.pe_tag;
            num_q   <= num_fv;
        end else if (issue_rd) begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stream.valid <= 1'b0;
            stream.sos   <= 1'b0;
            stream.eos   <= 1'b0;
        end else begin
            stream.valid  <= rvalid;
            stream.sos    <= rvalid && (out_cnt == '0);
            stream.eos    <= last_out;
            stream.pe_tag <= tag_q;
            stream.data   <= rdata;
        end
    end

    // the write in flight after eos still counts as busy.
    assign busy = (state == st_stream) || sram_req.wen;

    // PEs have no back-pressure, so a request while busy would be lost.
    req_while_busy_a: assert property (
        @(posedge clk) disable iff (reset)
        busy |-> !req.valid
    ) else $error("PE request while the bank is busy");

    load_while_stream_a: assert property (
        @(posedge clk) disable iff (reset)
        (state == st_stream) |-> !load.sos
    ) else $error("load burst started during a stream");

endmodule

`default_nettype wire

// ==== hw/fv_bank_top.sv ====
`default_nettype none

`include "fv_bank_cfg.svh"

module fv_bank_top (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      cfg_we,
    input  wire fv_bank_pkg::fv_num_t      cfg_wdata,
    output logic                           cfg_error,
    input  wire fv_bank_pkg::fv_load_t     load,
    input  wire fv_bank_pkg::fv_read_req_t req,
    output fv_bank_pkg::fv_stream_t        stream,
    output logic                           busy
);

    import fv_bank_pkg::*;

    fv_num_t           num_fv;
    fv_sram_req_t      sram_req;
    logic [`FV_BW-1:0] rdata;

    fv_bank_cfg_regs i_fv_bank_cfg_regs (
        .clk       (clk),
        .reset     (reset),
        .cfg_we    (cfg_we),
        .cfg_wdata (cfg_wdata),
        .num_fv    (num_fv),
        .cfg_error (cfg_error)
    );

    fv_bank_ctrl i_fv_bank_ctrl (
        .clk      (clk),
        .reset    (reset),
        .num_fv   (num_fv),
        .load     (load),
        .req      (req),
        .rdata    (rdata),
        .sram_req (sram_req),
        .stream   (stream),
        .busy     (busy)
    );

    fv_sram i_fv_sram (
        .clk      (clk),
        .sram_req (sram_req),
        .rdata    (rdata)
    );

endmodule

`default_nettype wire

// ==== tests/fv_bank_tb.sv ====
`default_nettype none

`include "fv_bank_cfg.svh"

module fv_bank_tb;

    import fv_bank_pkg::*;

    localparam int num_cases  = 8;
    localparam int wait_limit = 20;

    // one row of the case table.
    typedef struct packed {
        logic                  wr_cfg;
        fv_num_t               cfg;
        logic [`FV_ADDR_W-1:0] base;
        fv_tag_t               tag;
        logic                  do_load;
    } case_t;

    logic         clk;
    logic         reset;
    logic         cfg_we;
    fv_num_t      cfg_wdata;
    logic         cfg_error;
    fv_load_t     load;
    fv_read_req_t req;
    fv_stream_t   stream;
    logic         busy;

    case_t             cases [num_cases];
    logic [`FV_BW-1:0] model [`FV_BANK_DEPTH];
    logic [31:0]       lcg_state;
    fv_num_t           model_num;
    logic              model_err;
    int                errors;
    int                timeouts;
    int                checks;
    int                streams;

    fv_bank_top i_fv_bank_top (
        .clk       (clk),
        .reset     (reset),
        .cfg_we    (cfg_we),
        .cfg_wdata (cfg_wdata),
        .cfg_error (cfg_error),
        .load      (load),
        .req       (req),
        .stream    (stream),
        .busy      (busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic case_t make_row(input logic wr_cfg, input int cfg, input int base,
                                       input int tag, input logic do_load);
        case_t r;
        r.wr_cfg  = wr_cfg;
        r.cfg     = fv_num_t'(cfg);
        r.base    = base[`FV_ADDR_W-1:0];
        r.tag     = fv_tag_t'(tag);
        r.do_load = do_load;
        return r;
    endfunction

    // columns are: write config, config value, base address, PE tag, load first.
    task automatic fill_table();
        cases[0] = make_row(1'b1, 4, 'h10, 0, 1'b1);
        cases[1] = make_row(1'b1, 1, 'h40, 1, 1'b1);
        cases[2] = make_row(1'b1, `MAX_FV_NUM, 'h80, `NUM_EDGE_PE - 1, 1'b1);
        // no config write, so this request follows the previous stream directly.
        cases[3] = make_row(1'b0, 0, 'h80, 2, 1'b0);
        cases[4] = make_row(1'b1, 0, 'h20, 1, 1'b1);
        cases[5] = make_row(1'b1, `MAX_FV_NUM + 1, 'h20, `NUM_EDGE_PE - 1, 1'b0);
        // this vector wraps past the top of the bank.
        cases[6] = make_row(1'b1, 3, 'hfe, 2, 1'b1);
        cases[7] = make_row(1'b1, 2, 'h12, 0, 1'b0);
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic write_cfg(input fv_num_t value);
        cfg_we    = 1'b1;
        cfg_wdata = value;
        if (value != 0 && value <= `MAX_FV_NUM)
            model_num = value;
        else
            model_err = 1'b1;
        @(negedge clk);
        cfg_we = 1'b0;
        check(cfg_error, model_err, "cfg_error");
        check(busy, 1'b0, "busy after config write");
        check(stream.valid, 1'b0, "stream.valid after config write");
    endtask

    task automatic load_vector(input logic [`FV_ADDR_W-1:0] base, input fv_num_t len);
        logic [`FV_ADDR_W-1:0] addr;
        int                    k;
        int                    cnt;
        for (k = 0; k < len; k++) begin
            addr      = base + k;
            lcg_state = lcg(lcg_state);
            load.sos  = (k == 0);
            load.eos  = (k == len - 1);
            load.addr = addr;
            load.data = lcg_state;
            model[addr] = lcg_state;
            @(negedge clk);
            check(busy, 1'b1, "busy during load");
            check(stream.valid, 1'b0, "stream.valid during load");
        end
        load = '0;
        // the last write lands one edge after eos, then busy drops.
        cnt = 0;
        while (busy !== 1'b0 && cnt < wait_limit) begin
            @(negedge clk);
            cnt++;
        end
        if (busy !== 1'b0) begin
            timeouts++;
            $display("timeout at time %0t: busy stayed high after a load burst", $time);
        end else begin
            check(cnt, 1, "cycles from eos to busy low");
        end
    endtask

    task automatic request_vector(input logic [`FV_ADDR_W-1:0] base, input fv_tag_t tag,
                                  input fv_num_t len);
        logic [`FV_ADDR_W-1:0] addr;
        int                    lat;
        int                    k;
        req.valid  = 1'b1;
        req.addr   = base;
        req.pe_tag = tag;
        @(negedge clk);
        req = '0;
        lat = 1;
        check(busy, 1'b1, "busy after request");
        check(stream.valid, 1'b0, "stream.valid one cycle after request");
        while (stream.valid !== 1'b1 && lat < wait_limit) begin
            @(negedge clk);
            lat++;
            if (stream.valid !== 1'b1)
                check(busy, 1'b1, "busy before first word");
        end
        if (stream.valid !== 1'b1) begin
            timeouts++;
            $display("timeout at time %0t: no stream word for the request at %0h", $time, base);
        end else begin
            streams++;
            // one read cycle and one output register after the request edge.
            check(lat, 3, "cycles from request to first word");
            for (k = 0; k < len; k++) begin
                if (k > 0)
                    @(negedge clk);
                addr = base + k;
                check(stream.valid, 1'b1, "stream.valid");
                check(stream.sos, k == 0, "stream.sos");
                check(stream.eos, k == len - 1, "stream.eos");
                check(stream.pe_tag, tag, "stream.pe_tag");
                check(stream.data, model[addr], "stream.data");
                check(busy, k != len - 1, "busy during stream");
            end
        end
    endtask

    initial begin
        int i;
        reset     = 1'b1;
        cfg_we    = 1'b0;
        cfg_wdata = '0;
        load      = '0;
        req       = '0;
        errors    = 0;
        timeouts  = 0;
        checks    = 0;
        streams   = 0;
        lcg_state = 32'd12590;
        model_num = fv_num_t'(1);
        model_err = 1'b0;
        fill_table();

        repeat (3) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check(stream.valid, 1'b0, "stream.valid after reset");
        check(busy, 1'b0, "busy after reset");
        check(cfg_error, 1'b0, "cfg_error after reset");

        for (i = 0; i < num_cases; i++) begin
            if (cases[i].wr_cfg)
                write_cfg(cases[i].cfg);
            if (cases[i].do_load)
                load_vector(cases[i].base, model_num);
            request_vector(cases[i].base, cases[i].tag, model_num);
        end

        // nothing may follow the last word.
        @(negedge clk);
        check(stream.valid, 1'b0, "stream.valid after the last stream");
        check(busy, 1'b0, "busy after the last stream");
        check(cfg_error, model_err, "cfg_error at the end");

        $display("checks %0d, streams %0d, errors %0d, timeouts %0d",
                 checks, streams, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
hw/fv_bank_pkg.sv
hw/fv_bank_cfg_regs.sv
hw/fv_sram.sv
hw/fv_bank_ctrl.sv
hw/fv_bank_top.sv
tests/fv_bank_tb.sv

// ==== Bender.yml ====
package:
  name: fv_bank

sources:
  - include_dirs:
      - include
    files:
      - hw/fv_bank_pkg.sv
      - hw/fv_bank_cfg_regs.sv
      - hw/fv_sram.sv
      - hw/fv_bank_ctrl.sv
      - hw/fv_bank_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - tests/fv_bank_tb.sv
